// File: logic/glb_pkg.sv
package glb_pkg;

    // Bank number field of a host word address
    localparam int BANK_SEL_WIDTH = 2;                                  // Upper bits pick the bank

    // One bank per value of the bank number field
    localparam int NUM_BANKS = 2 ** BANK_SEL_WIDTH;                     // Four banks in total

    // Word address inside one bank
    localparam int BANK_ADDR_WIDTH = 10;                                // 1024 words per bank

    // Host word address covers every bank
    localparam int GLB_ADDR_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;   // Twelve address bits

    // Data word and per-bit write select share one width
    localparam int BANK_DATA_WIDTH = 64;                                // One 64-bit word per access

    // Field view of a host address
    typedef struct packed {
        logic [BANK_SEL_WIDTH-1:0]  bank_sel;                           // Bank number in the top bits
        logic [BANK_ADDR_WIDTH-1:0] bank_addr;                          // Word inside that bank
    } glb_addr_field_t;

    // A host address is either one flat number or the bank and word pair
    typedef union packed {
        logic [GLB_ADDR_WIDTH-1:0] flat;                                // Plain host word address
        glb_addr_field_t           field;                               // Split into bank and word
    } glb_addr_t;

endpackage

// File: logic/glb_packet_demux.sv
module glb_packet_demux (
    // Host write request
    input  logic                                packet_wr_en,
    input  glb_pkg::glb_addr_t                  packet_wr_addr,

    // Host read request
    input  logic                                packet_rd_en,
    input  glb_pkg::glb_addr_t                  packet_rd_addr,

    // One strobe per bank
    output logic [glb_pkg::NUM_BANKS-1:0]       bank_wr_en,
    output logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_en,

    // In-bank word addresses shared by all banks
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] bank_wr_addr,
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] bank_rd_addr
);

    import glb_pkg::*;

    logic [BANK_SEL_WIDTH-1:0] wr_bank_sel;                         // Bank targeted by the write
    logic [BANK_SEL_WIDTH-1:0] rd_bank_sel;                         // Bank targeted by the read

    // Split both host addresses through the field view of the union
    assign wr_bank_sel  = packet_wr_addr.field.bank_sel;            // Upper bits of the write address
    assign rd_bank_sel  = packet_rd_addr.field.bank_sel;            // Upper bits of the read address
    assign bank_wr_addr = packet_wr_addr.field.bank_addr;           // Only the word part goes on
    assign bank_rd_addr = packet_rd_addr.field.bank_addr;           // Same for the read side

    // Write strobe decode
    always_comb begin
        bank_wr_en = '0;                                            // No bank written by default
        if (packet_wr_en) begin
            bank_wr_en[wr_bank_sel] = 1'b1;                         // Exactly one bank sees the write
        end
    end

    // Read strobe decode
    always_comb begin
        bank_rd_en = '0;                                            // No bank read by default
        if (packet_rd_en) begin
            bank_rd_en[rd_bank_sel] = 1'b1;                         // Exactly one bank sees the read
        end
    end

    // A write and a read may land on the same bank here
    // The bank controller decides which one goes ahead

endmodule

// File: logic/glb_bank_ctrl.sv
module glb_bank_ctrl (
    input  logic                                clk,
    input  logic                                reset,

    // Write request from the demultiplexer
    input  logic                                wr_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data_bit_sel,

    // Read request and its returned word
    input  logic                                rd_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic                                rd_data_valid,

    // Memory side
    output logic                                mem_rd_en,
    output logic                                mem_wr_en,
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] mem_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in_bit_sel,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out
);

    import glb_pkg::*;

    logic                       mem_rd_en_d1;                       // Read issued to memory last cycle
    logic [BANK_DATA_WIDTH-1:0] rd_data_d1;                         // Last word handed out

    // Write has priority over read on this bank
    always_comb begin
        if (wr_en) begin
            mem_wr_en           = 1'b1;                             // Write goes to memory
            mem_rd_en           = 1'b0;                             // A colliding read is dropped
            mem_addr            = wr_addr;
            mem_data_in         = wr_data;
            mem_data_in_bit_sel = wr_data_bit_sel;                  // Only selected bits change
        end
        else if (rd_en) begin
            mem_wr_en           = 1'b0;
            mem_rd_en           = 1'b1;                             // Read goes to memory
            mem_addr            = rd_addr;
            mem_data_in         = '0;                               // Idle write data stays zero
            mem_data_in_bit_sel = '0;
        end
        else begin
            mem_wr_en           = 1'b0;                             // Nothing to do this cycle
            mem_rd_en           = 1'b0;
            mem_addr            = '0;
            mem_data_in         = '0;
            mem_data_in_bit_sel = '0;
        end
    end

    // Track the executed read so a dropped read never raises valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_rd_en_d1 <= 1'b0;
            rd_data_d1   <= '0;
        end
        else begin
            mem_rd_en_d1 <= mem_rd_en;                              // Memory word appears one edge later
            rd_data_d1   <= rd_data;                                // Remember what was presented
        end
    end

    // Fresh word while a read returns and the previous word otherwise
    assign rd_data       = mem_rd_en_d1 ? mem_data_out : rd_data_d1;
    assign rd_data_valid = mem_rd_en_d1;                            // High for the return cycle only

endmodule

// File: logic/glb_bank_memory.sv
module glb_bank_memory (
    input  logic                                clk,
    input  logic                                reset,

    // Access from the bank controller
    input  logic                                mem_rd_en,
    input  logic                                mem_wr_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] mem_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_in_bit_sel,

    // Registered read word
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] mem_data_out
);

    import glb_pkg::*;

    logic [BANK_DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];           // Word storage of one bank
    logic [BANK_DATA_WIDTH-1:0] wr_word;                            // Stored word after the masked merge

    // Keep the bits whose select is zero and take new data elsewhere
    assign wr_word = (mem[mem_addr] & ~mem_data_in_bit_sel)
                   | (mem_data_in & mem_data_in_bit_sel);

    // Storage array with bit-select write
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_addr] <= wr_word;                               // Updated at the sampling edge
        end
    end

    // Read port registers the addressed word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_data_out <= '0;                                     // Output register starts clear
        end
        else if (mem_rd_en) begin
            mem_data_out <= mem[mem_addr];                          // Sees contents from before this edge
        end
    end

    // Between reads mem_data_out keeps the last word read
    // The controller only uses it in the cycle after a read

endmodule

// File: logic/glb_rd_data_collector.sv
module glb_rd_data_collector (
    input  logic                                clk,
    input  logic                                reset,

    // Return data from every bank controller
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] bank_rd_data [glb_pkg::NUM_BANKS],
    input  logic [glb_pkg::NUM_BANKS-1:0]       bank_rd_data_valid,

    // Registered host read return
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_rd_data,
    output logic                                packet_rd_data_valid
);

    import glb_pkg::*;

    logic [BANK_DATA_WIDTH-1:0] sel_data;                           // Word chosen for this cycle
    logic                       any_valid;                          // Some bank is returning data

    // Only one read per cycle so at most one bank returns
    always_comb begin
        sel_data = packet_rd_data;                                  // Keep the old word when idle
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_rd_data_valid[b]) begin
                sel_data = bank_rd_data[b];                         // Take the returning bank's word
            end
        end
    end

    assign any_valid = |bank_rd_data_valid;                         // OR of all bank valids

    // Host output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_rd_data       <= '0;                             // Host data reads zero after reset
            packet_rd_data_valid <= 1'b0;
        end
        else begin
            packet_rd_data       <= sel_data;                       // Holds while no bank is valid
            packet_rd_data_valid <= any_valid;                      // One-cycle pulse per return
        end
    end

endmodule

// File: logic/global_buffer.sv
module global_buffer (
    input  logic                                clk,
    input  logic                                reset,

    // Host write
    input  logic                                packet_wr_en,
    input  glb_pkg::glb_addr_t                  packet_wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_wr_data,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_wr_data_bit_sel,

    // Host read request
    input  logic                                packet_rd_en,
    input  glb_pkg::glb_addr_t                  packet_rd_addr,

    // Host read return
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] packet_rd_data,
    output logic                                packet_rd_data_valid
);

    import glb_pkg::*;

    logic [NUM_BANKS-1:0]       bank_wr_en;                         // Per-bank write strobes
    logic [NUM_BANKS-1:0]       bank_rd_en;                         // Per-bank read strobes
    logic [BANK_ADDR_WIDTH-1:0] bank_wr_addr;                       // Shared in-bank write address
    logic [BANK_ADDR_WIDTH-1:0] bank_rd_addr;                       // Shared in-bank read address
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data [NUM_BANKS];           // Return word of each bank
    logic [NUM_BANKS-1:0]       bank_rd_data_valid;                 // Return valid of each bank

    // Memory side nets between each controller and its memory
    logic [NUM_BANKS-1:0]       mem_rd_en;
    logic [NUM_BANKS-1:0]       mem_wr_en;
    logic [BANK_ADDR_WIDTH-1:0] mem_addr            [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] mem_data_in         [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] mem_data_in_bit_sel [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] mem_data_out        [NUM_BANKS];

    // Steer the host strobes to one bank each
    glb_packet_demux glb_packet_demux_i (
        .packet_wr_en   (packet_wr_en),
        .packet_wr_addr (packet_wr_addr),
        .packet_rd_en   (packet_rd_en),
        .packet_rd_addr (packet_rd_addr),
        .bank_wr_en     (bank_wr_en),
        .bank_rd_en     (bank_rd_en),
        .bank_wr_addr   (bank_wr_addr),
        .bank_rd_addr   (bank_rd_addr)
    );

    // One controller and one memory per bank
    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        glb_bank_ctrl glb_bank_ctrl_i (
            .clk                 (clk),
            .reset               (reset),
            .wr_en               (bank_wr_en[i]),
            .wr_addr             (bank_wr_addr),
            .wr_data             (packet_wr_data),                  // Write data fans out to all banks
            .wr_data_bit_sel     (packet_wr_data_bit_sel),
            .rd_en               (bank_rd_en[i]),
            .rd_addr             (bank_rd_addr),
            .rd_data             (bank_rd_data[i]),
            .rd_data_valid       (bank_rd_data_valid[i]),
            .mem_rd_en           (mem_rd_en[i]),
            .mem_wr_en           (mem_wr_en[i]),
            .mem_addr            (mem_addr[i]),
            .mem_data_in         (mem_data_in[i]),
            .mem_data_in_bit_sel (mem_data_in_bit_sel[i]),
            .mem_data_out        (mem_data_out[i])
        );

        glb_bank_memory glb_bank_memory_i (
            .clk                 (clk),
            .reset               (reset),
            .mem_rd_en           (mem_rd_en[i]),
            .mem_wr_en           (mem_wr_en[i]),
            .mem_addr            (mem_addr[i]),
            .mem_data_in         (mem_data_in[i]),
            .mem_data_in_bit_sel (mem_data_in_bit_sel[i]),
            .mem_data_out        (mem_data_out[i])
        );
    end

    // Merge the bank returns onto the host port
    glb_rd_data_collector glb_rd_data_collector_i (
        .clk                  (clk),
        .reset                (reset),
        .bank_rd_data         (bank_rd_data),
        .bank_rd_data_valid   (bank_rd_data_valid),
        .packet_rd_data       (packet_rd_data),
        .packet_rd_data_valid (packet_rd_data_valid)
    );

endmodule

// File: sim/global_buffer_props.sv
module global_buffer_props (
    input logic                          clk,
    input logic                          reset,
    input logic [glb_pkg::NUM_BANKS-1:0] mem_wr_en,
    input logic [glb_pkg::NUM_BANKS-1:0] mem_rd_en,
    input logic                          packet_rd_data_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    import glb_pkg::*;

    // A bank memory never sees a write and a read in the same cycle
    no_wr_rd_overlap: assert property (@(posedge clk) disable iff (reset)
        (mem_wr_en & mem_rd_en) == '0)
        else $error("Bank memory got write and read enables together");

    // Every read that reaches a memory returns on the host two edges later
    rd_valid_latency: assert property (@(posedge clk) disable iff (reset)
        (|mem_rd_en) |-> ##2 packet_rd_data_valid)
        else $error("Host read valid missing two edges after an executed read");

    // Host valid only ever comes from a read that reached a memory
    rd_valid_source: assert property (@(posedge clk) disable iff (reset)
        packet_rd_data_valid |-> $past(|mem_rd_en, 2))
        else $error("Host read valid without an executed read two edges before");

    // Nothing is returned while reset is applied
    valid_low_in_reset: assert property (@(posedge clk)
        reset |-> !packet_rd_data_valid)
        else $error("Host read valid high during reset");

endmodule

// Attach the checks to every instance of the top level
bind global_buffer global_buffer_props global_buffer_props_i (
    .clk                  (clk),
    .reset                (reset),
    .mem_wr_en            (mem_wr_en),
    .mem_rd_en            (mem_rd_en),
    .packet_rd_data_valid (packet_rd_data_valid)
);

// File: sim/global_buffer_tb.sv
module global_buffer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import glb_pkg::*;

    localparam int RD_TIMEOUT = 20;                                 // Cycles allowed for a read return

    logic                       clk;
    logic                       reset;
    logic                       packet_wr_en;
    glb_addr_t                  packet_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] packet_wr_data;
    logic [BANK_DATA_WIDTH-1:0] packet_wr_data_bit_sel;
    logic                       packet_rd_en;
    glb_addr_t                  packet_rd_addr;
    logic [BANK_DATA_WIDTH-1:0] packet_rd_data;
    logic                       packet_rd_data_valid;

    logic [BANK_DATA_WIDTH-1:0] model_mem [logic [GLB_ADDR_WIDTH-1:0]];  // Reference contents
    logic [BANK_DATA_WIDTH-1:0] exp_q [$];                          // Expected words of reads in flight
    logic [BANK_DATA_WIDTH-1:0] last_word;                          // Word the host port should be holding
    int                         mismatch_count;
    int                         fail_count;

    global_buffer global_buffer_i (
        .clk                    (clk),
        .reset                  (reset),
        .packet_wr_en           (packet_wr_en),
        .packet_wr_addr         (packet_wr_addr),
        .packet_wr_data         (packet_wr_data),
        .packet_wr_data_bit_sel (packet_wr_data_bit_sel),
        .packet_rd_en           (packet_rd_en),
        .packet_rd_addr         (packet_rd_addr),
        .packet_rd_data         (packet_rd_data),
        .packet_rd_data_valid   (packet_rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                                     // 100 ns period
    end

    // Inputs change and outputs are looked at 10 ns after each rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic glb_addr_t make_addr(input logic [BANK_SEL_WIDTH-1:0]  bank,
                                            input logic [BANK_ADDR_WIDTH-1:0] word);
        glb_addr_t a;
        a.flat = {bank, word};                                      // Bank number sits in the top bits
        return a;
    endfunction

    function automatic logic [BANK_SEL_WIDTH-1:0] bank_of(input glb_addr_t a);
        return a.flat[GLB_ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
    endfunction

    function automatic logic [BANK_DATA_WIDTH-1:0] random_data();
        return {$urandom(), $urandom()};                            // Two 32-bit draws make one word
    endfunction

    function automatic logic [BANK_ADDR_WIDTH-1:0] random_word_addr();
        logic [31:0] r;
        r = $urandom();
        return r[BANK_ADDR_WIDTH-1:0];
    endfunction

    function automatic logic [BANK_DATA_WIDTH-1:0] model_read(input glb_addr_t a);
        if (model_mem.exists(a.flat)) begin
            return model_mem[a.flat];
        end
        return '0;                                                  // Only written words are read back
    endfunction

    // Selected bits take the new data and the others keep the old word
    function automatic void model_write(input glb_addr_t                  a,
                                        input logic [BANK_DATA_WIDTH-1:0] data,
                                        input logic [BANK_DATA_WIDTH-1:0] mask);
        logic [BANK_DATA_WIDTH-1:0] old;
        old = model_read(a);
        model_mem[a.flat] = (old & ~mask) | (data & mask);
    endfunction

    task automatic check_data(input string                      name,
                              input logic [BANK_DATA_WIDTH-1:0] expected,
                              input logic [BANK_DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic drive_write(input glb_addr_t                  a,
                               input logic [BANK_DATA_WIDTH-1:0] data,
                               input logic [BANK_DATA_WIDTH-1:0] mask);
        packet_wr_en           = 1'b1;
        packet_wr_addr         = a;
        packet_wr_data         = data;
        packet_wr_data_bit_sel = mask;
        model_write(a, data, mask);
        step();                                                     // Sampled at this edge
        packet_wr_en           = 1'b0;
    endtask

    task automatic drive_read(input glb_addr_t a);
        packet_rd_en   = 1'b1;
        packet_rd_addr = a;
        exp_q.push_back(model_read(a));
        step();
        packet_rd_en   = 1'b0;
    endtask

    // Same bank means the write wins and the read is lost
    task automatic drive_write_read(input glb_addr_t                  wa,
                                    input logic [BANK_DATA_WIDTH-1:0] data,
                                    input logic [BANK_DATA_WIDTH-1:0] mask,
                                    input glb_addr_t                  ra);
        packet_wr_en           = 1'b1;
        packet_wr_addr         = wa;
        packet_wr_data         = data;
        packet_wr_data_bit_sel = mask;
        packet_rd_en           = 1'b1;
        packet_rd_addr         = ra;
        if (bank_of(wa) != bank_of(ra)) begin
            exp_q.push_back(model_read(ra));                        // Read sees the old contents
        end
        model_write(wa, data, mask);
        step();
        packet_wr_en           = 1'b0;
        packet_rd_en           = 1'b0;
    endtask

    // Wait for the next valid pulse and compare it with the oldest expected word
    task automatic collect_read();
        int                         cycles;
        logic [BANK_DATA_WIDTH-1:0] expected;
        cycles = 0;
        while (packet_rd_data_valid !== 1'b1 && cycles < RD_TIMEOUT) begin
            step();
            cycles++;
        end
        if (packet_rd_data_valid !== 1'b1) begin
            $display("ERROR at %0t: read never returned within %0d cycles", $time, RD_TIMEOUT);
            fail_count++;
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();                       // Drop it to stay in step
            end
        end
        else if (exp_q.size() == 0) begin
            $display("ERROR at %0t: read data returned with no read outstanding", $time);
            fail_count++;
            step();
        end
        else begin
            expected = exp_q.pop_front();
            check_data("packet_rd_data", expected, packet_rd_data);
            last_word = expected;
            step();
        end
    endtask

    // Host port must stay quiet and keep its word
    task automatic hold_check(input int cycles, input logic [BANK_DATA_WIDTH-1:0] held);
        repeat (cycles) begin
            check_bit("packet_rd_data_valid", 1'b0, packet_rd_data_valid);
            check_data("packet_rd_data", held, packet_rd_data);
            step();
        end
    endtask

    task automatic test_reset_state();
        repeat (8) begin
            step();
            check_bit("packet_rd_data_valid", 1'b0, packet_rd_data_valid);
            check_data("packet_rd_data", '0, packet_rd_data);
        end
        reset = 1'b0;                                               // Released between edges
        hold_check(3, '0);
        last_word = '0;
    endtask

    task automatic test_write_read_all_banks();
        glb_addr_t addr_q [$];
        for (int b = 0; b < NUM_BANKS; b++) begin
            addr_q.push_back(make_addr(b[BANK_SEL_WIDTH-1:0], '0));           // First word
            addr_q.push_back(make_addr(b[BANK_SEL_WIDTH-1:0], '1));           // Last word
            addr_q.push_back(make_addr(b[BANK_SEL_WIDTH-1:0], random_word_addr()));
        end
        foreach (addr_q[i]) begin
            drive_write(addr_q[i], random_data(), '1);
        end
        for (int i = 0; i < 4; i++) begin
            drive_read(addr_q[i]);                                  // One read at a time
            collect_read();
        end
        fork
            begin
                for (int i = 4; i < addr_q.size(); i++) begin
                    drive_read(addr_q[i]);                          // One read per cycle
                end
            end
            begin
                repeat (addr_q.size() - 4) collect_read();
            end
        join
        hold_check(3, last_word);                                   // No extra pulses
    endtask

    task automatic test_bit_select();
        glb_addr_t a;
        a = make_addr(2'd2, random_word_addr());
        drive_write(a, 64'ha5a5_5a5a_f00f_0ff0, '1);
        drive_write(a, random_data(), random_data());               // Random data under a random mask
        drive_read(a);
        collect_read();
    endtask

    task automatic test_same_bank_collision();
        glb_addr_t wa;
        glb_addr_t ra;
        wa = make_addr(2'd1, 10'h155);
        ra = make_addr(2'd1, 10'h2aa);
        drive_write(ra, random_data(), '1);
        drive_read(ra);
        collect_read();                                             // Host now holds a known word
        drive_write_read(wa, random_data(), '1, ra);
        hold_check(RD_TIMEOUT, last_word);                          // Dropped read gives no pulse
        drive_read(wa);
        collect_read();
    endtask

    task automatic test_diff_bank_access();
        glb_addr_t                  wa;
        glb_addr_t                  ra;
        logic [BANK_ADDR_WIDTH-1:0] word;
        word = random_word_addr();
        wa   = make_addr(2'd3, word);
        ra   = make_addr(2'd0, word);                               // Same word in another bank
        drive_write(wa, random_data(), '1);
        drive_write(ra, random_data(), '1);
        drive_write_read(wa, random_data(), '1, ra);
        collect_read();
        drive_read(wa);
        collect_read();
    endtask

    task automatic test_hold_between_reads();
        glb_addr_t a;
        a = make_addr(2'd0, 10'h001);
        drive_write(a, random_data(), '1);
        drive_read(a);
        collect_read();
        hold_check(6, last_word);
    endtask

    initial begin
        void'($urandom(32'h8e8f_8f7b));                             // One seed for the whole run
        mismatch_count         = 0;
        fail_count             = 0;
        last_word              = '0;
        reset                  = 1'b1;
        packet_wr_en           = 1'b0;
        packet_wr_addr         = '0;
        packet_wr_data         = '0;
        packet_wr_data_bit_sel = '0;
        packet_rd_en           = 1'b0;
        packet_rd_addr         = '0;

        test_reset_state();
        test_write_read_all_banks();
        test_bit_select();
        test_same_bank_collision();
        test_diff_bank_access();
        test_hold_between_reads();

        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("All tests passed");
        end
        else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/glb_pkg.sv
logic/glb_packet_demux.sv
logic/glb_bank_ctrl.sv
logic/glb_bank_memory.sv
logic/glb_rd_data_collector.sv
logic/global_buffer.sv
sim/global_buffer_props.sv
sim/global_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the global buffer simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module global_buffer_tb -f verilog.f -o sim_global_buffer

status=0
sim_output=$(./obj_dir/sim_global_buffer 2>&1) || status=$?
echo "$sim_output"

if [ "$status" -ne 0 ]; then
    exit "$status"
fi

if echo "$sim_output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
